/* common/rv_pkg.sv */
package rv_pkg;

  // Micro-op kinds coming out of decode
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_CSRRW,
    OP_CSRRS,
    OP_ECALL,
    OP_MRET
  } op_e;

  // One decoded micro-op
  typedef struct packed {
    op_e         op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [11:0] csr;
    logic [31:0] pc;
  } uop_t;

  // Register writeback, one cycle after issue
  typedef struct packed {
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  // Trap controller states
  typedef enum logic [1:0] {
    ST_RUN,
    ST_ENTER,
    ST_RETURN
  } trap_st_e;

  // Machine CSR addresses
  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MIE      = 12'h304;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MIP      = 12'h344;
  // Custom slot for the timer compare, read-only mirror of the counter
  localparam logic [11:0] CSR_MTIMECMP = 12'h7C0;
  localparam logic [11:0] CSR_MTIME    = 12'hC01;

  // mcause values
  localparam logic [31:0] CAUSE_ECALL_M   = 32'd11;
  localparam logic [31:0] CAUSE_TIMER_IRQ = 32'h8000_0007;

  // Bit positions in mstatus, mie and mip
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MIP_MTIP     = 7;
  localparam int MIE_MTIE     = 7;

endpackage

/* regfile/reg_file.sv */
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  wb_t         wb,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];
  logic        fwd1;
  logic        fwd2;

  // Bypass when the writeback in flight targets the register being read
  // x0 never forwards, it stays zero
  assign fwd1 = wb.we && (wb.rd == rs1) && (rs1 != 5'd0);
  assign fwd2 = wb.we && (wb.rd == rs2) && (rs2 != 5'd0);

  always_comb begin
    if (fwd1) begin
      rdata1 = wb.data;
    end else begin
      rdata1 = regs[rs1];
    end
  end

  always_comb begin
    if (fwd2) begin
      rdata2 = wb.data;
    end else begin
      rdata2 = regs[rs2];
    end
  end

  // Array write, x0 left at its reset value
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

/* regfile/csr_file.sv */
`timescale 1ns/10ps

module csr_file import rv_pkg::*; #(
  parameter int TIMER_W = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               csr_en,
  input  op_e                op,
  input  logic [11:0]        csr,
  input  logic [31:0]        wdata,
  input  logic               set_en,
  input  logic               trap_enter,
  input  logic [31:0]        trap_cause,
  input  logic [31:0]        trap_pc,
  input  logic               trap_return,
  input  logic [TIMER_W-1:0] mtime,
  input  logic [TIMER_W-1:0] mtimecmp,
  input  logic               irq,
  output logic [31:0]        rdata,
  output logic [31:0]        mtvec,
  output logic [31:0]        mepc,
  output logic               irq_pending,
  output logic               cmp_we,
  output logic [TIMER_W-1:0] cmp_data
);

  // Only MIE and MPIE are implemented in mstatus, only MTIE in mie
  logic        st_mie;
  logic        st_mpie;
  logic        mtie;
  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] mstatus_val;
  logic [31:0] mie_val;
  logic [31:0] mip_val;
  logic [31:0] new_val;
  logic        wr_en;

  always_comb begin
    mstatus_val = '0;
    mstatus_val[MSTATUS_MIE] = st_mie;
    mstatus_val[MSTATUS_MPIE] = st_mpie;
    mie_val = '0;
    mie_val[MIE_MTIE] = mtie;
    mip_val = '0;
    mip_val[MIP_MTIP] = irq;
  end

  // Old value mux, unknown addresses read zero
  always_comb begin
    case (csr)
      CSR_MSTATUS:  rdata = mstatus_val;
      CSR_MIE:      rdata = mie_val;
      CSR_MTVEC:    rdata = mtvec;
      CSR_MSCRATCH: rdata = mscratch;
      CSR_MEPC:     rdata = mepc;
      CSR_MCAUSE:   rdata = mcause;
      CSR_MIP:      rdata = mip_val;
      CSR_MTIMECMP: rdata = 32'(mtimecmp);
      CSR_MTIME:    rdata = 32'(mtime);
      default:      rdata = '0;
    endcase
  end

  // CSRRS with rs1 = x0 is a pure read
  assign new_val = (op == OP_CSRRW) ? wdata : (rdata | wdata);
  assign wr_en   = csr_en && ((op == OP_CSRRW) || set_en);

  // Compare register lives in the timer
  assign cmp_we   = wr_en && (csr == CSR_MTIMECMP);
  assign cmp_data = TIMER_W'(new_val);

  assign irq_pending = irq && mtie && st_mie;

  always_ff @(posedge clk) begin
    if (reset) begin
      st_mie   <= 1'b0;
      st_mpie  <= 1'b0;
      mtie     <= 1'b0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (trap_enter) begin
      mepc    <= trap_pc;
      mcause  <= trap_cause;
      st_mpie <= st_mie;
      st_mie  <= 1'b0;
    end else if (trap_return) begin
      st_mie  <= st_mpie;
      st_mpie <= 1'b1;
    end else if (wr_en) begin
      case (csr)
        CSR_MSTATUS: begin
          st_mie  <= new_val[MSTATUS_MIE];
          st_mpie <= new_val[MSTATUS_MPIE];
        end
        CSR_MIE:      mtie     <= new_val[MIE_MTIE];
        CSR_MTVEC:    mtvec    <= new_val;
        CSR_MSCRATCH: mscratch <= new_val;
        CSR_MEPC:     mepc     <= new_val;
        CSR_MCAUSE:   mcause   <= new_val;
        // mip and mtime are read-only
        default: ;
      endcase
    end
  end

endmodule

/* logic/exec_alu.sv */
`timescale 1ns/10ps

module exec_alu import rv_pkg::*; (
  input  op_e         op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [31:0] imm,
  output logic [31:0] result
);

  // Register-register ops use a and b
  // ADDI and LUI take the decoded immediate
  always_comb begin
    case (op)
      OP_ADD: begin
        result = a + b;
      end
      OP_SUB: begin
        result = a - b;
      end
      OP_AND: begin
        result = a & b;
      end
      OP_OR: begin
        result = a | b;
      end
      OP_XOR: begin
        result = a ^ b;
      end
      OP_ADDI: begin
        result = a + imm;
      end
      OP_LUI: begin
        // Immediate arrives already shifted into place
        result = imm;
      end
      default: begin
        // CSR, ecall and mret produce no ALU result
        result = '0;
      end
    endcase
  end

endmodule

/* logic/trap_ctrl.sv */
`timescale 1ns/10ps

module trap_ctrl import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        op_valid,
  input  uop_t        op,
  input  logic        irq_pending,
  input  logic [31:0] mtvec,
  input  logic [31:0] mepc,
  output logic        exec_en,
  output logic        trap_enter,
  output logic [31:0] trap_cause,
  output logic [31:0] trap_pc,
  output logic        trap_return,
  output logic        busy,
  output logic        redirect,
  output logic [31:0] redirect_pc
);

  trap_st_e state;
  trap_st_e state_next;
  logic     accept;
  logic     take_irq;

  // Ops only land while running
  assign accept   = op_valid && (state == ST_RUN);
  // Pending interrupt wins over the op that would issue
  assign take_irq = accept && irq_pending;

  always_comb begin
    state_next = state;
    exec_en    = 1'b0;
    case (state)
      ST_RUN: begin
        if (take_irq) begin
          state_next = ST_ENTER;
        end else if (accept && (op.op == OP_ECALL)) begin
          state_next = ST_ENTER;
        end else if (accept && (op.op == OP_MRET)) begin
          state_next = ST_RETURN;
        end else begin
          exec_en = accept;
        end
      end
      default: begin
        // Entry and return last one cycle each
        state_next = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_RUN;
    end else begin
      state <= state_next;
    end
  end

  // Cause and pc held for the entry cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      trap_cause <= take_irq ? CAUSE_TIMER_IRQ : CAUSE_ECALL_M;
      trap_pc    <= op.pc;
    end
  end

  assign trap_enter  = (state == ST_ENTER);
  assign trap_return = (state == ST_RETURN);
  assign busy        = (state != ST_RUN);
  assign redirect    = trap_enter || trap_return;
  // mtvec is still the old value during entry
  assign redirect_pc = trap_return ? mepc : mtvec;

endmodule

/* logic/machine_timer.sv */
`timescale 1ns/10ps

module machine_timer #(
  parameter int TIMER_W = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmp_we,
  input  logic [TIMER_W-1:0] cmp_data,
  output logic [TIMER_W-1:0] mtime,
  output logic [TIMER_W-1:0] mtimecmp,
  output logic               irq
);

  // Free-running time base
  always_ff @(posedge clk) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  // Compare starts at all ones so no interrupt fires out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      mtimecmp <= '1;
    end else if (cmp_we) begin
      mtimecmp <= cmp_data;
    end
  end

  // Level request, drops only when compare moves ahead
  assign irq = (mtime >= mtimecmp);

endmodule

/* logic/exec_top.sv */
`timescale 1ns/10ps

module exec_top import rv_pkg::*; #(
  parameter int TIMER_W = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        op_valid,
  input  uop_t        op,
  output logic        busy,
  output wb_t         wb,
  output logic        redirect,
  output logic [31:0] redirect_pc
);

  logic               exec_en;
  logic               trap_enter;
  logic [31:0]        trap_cause;
  logic [31:0]        trap_pc;
  logic               trap_return;
  logic               irq_pending;
  logic [31:0]        mtvec;
  logic [31:0]        mepc;
  logic [31:0]        rdata1;
  logic [31:0]        rdata2;
  logic [31:0]        alu_result;
  logic [31:0]        csr_rdata;
  logic               is_csr;
  logic               is_wb_op;
  logic               cmp_we;
  logic [TIMER_W-1:0] cmp_data;
  logic [TIMER_W-1:0] mtime;
  logic [TIMER_W-1:0] mtimecmp;
  logic               irq;

  assign is_csr   = (op.op == OP_CSRRW) || (op.op == OP_CSRRS);
  // Everything but ecall and mret writes rd
  assign is_wb_op = (op.op != OP_ECALL) && (op.op != OP_MRET);

  trap_ctrl u_trap_ctrl (
    .clk(clk), .reset(reset), .op_valid(op_valid), .op(op),
    .irq_pending(irq_pending), .mtvec(mtvec), .mepc(mepc),
    .exec_en(exec_en), .trap_enter(trap_enter), .trap_cause(trap_cause),
    .trap_pc(trap_pc), .trap_return(trap_return), .busy(busy),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  reg_file u_reg_file (
    .clk(clk), .reset(reset), .rs1(op.rs1), .rs2(op.rs2), .wb(wb),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  exec_alu u_exec_alu (
    .op(op.op), .a(rdata1), .b(rdata2), .imm(op.imm), .result(alu_result)
  );

  csr_file #(.TIMER_W(TIMER_W)) u_csr_file (
    .clk(clk), .reset(reset), .csr_en(exec_en && is_csr), .op(op.op),
    .csr(op.csr), .wdata(rdata1), .set_en(op.rs1 != 5'd0),
    .trap_enter(trap_enter), .trap_cause(trap_cause), .trap_pc(trap_pc),
    .trap_return(trap_return), .mtime(mtime), .mtimecmp(mtimecmp), .irq(irq),
    .rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc), .irq_pending(irq_pending),
    .cmp_we(cmp_we), .cmp_data(cmp_data)
  );

  machine_timer #(.TIMER_W(TIMER_W)) u_machine_timer (
    .clk(clk), .reset(reset), .cmp_we(cmp_we), .cmp_data(cmp_data),
    .mtime(mtime), .mtimecmp(mtimecmp), .irq(irq)
  );

  // Writeback register, CSR ops return the old CSR value
  always_ff @(posedge clk) begin
    if (reset) begin
      wb.we <= 1'b0;
    end else begin
      wb.we <= exec_en && is_wb_op && (op.rd != 5'd0);
    end
    wb.rd   <= op.rd;
    wb.data <= is_csr ? csr_rdata : alu_result;
  end

endmodule

/* tb/exec_props.sv */
`timescale 1ns/10ps

module exec_props import rv_pkg::*; (
  input logic clk,
  input logic reset,
  input logic busy,
  input logic redirect,
  input wb_t  wb
);

  // Redirect is a single-cycle pulse
  redirect_pulse: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !redirect)
    else $error("redirect high for more than one cycle");

  // Redirect only during entry or return
  redirect_busy: assert property (@(posedge clk) disable iff (reset)
    redirect |-> busy)
    else $error("redirect without busy");

  // x0 never written
  wb_rd_zero: assert property (@(posedge clk) disable iff (reset)
    wb.we |-> (wb.rd != 5'd0))
    else $error("writeback enabled with rd zero");

  // Entry and return last one cycle
  busy_single: assert property (@(posedge clk) disable iff (reset)
    busy |=> !busy)
    else $error("busy high for two cycles in a row");

endmodule

bind exec_top exec_props props (
  .clk(clk), .reset(reset), .busy(busy), .redirect(redirect), .wb(wb)
);

/* tb/exec_tb.sv */
`timescale 1ns/10ps

module exec_tb import rv_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic        clk = 1'b0;
  logic        reset;
  logic        op_valid;
  uop_t        op;
  logic        busy;
  wb_t         wb;
  logic        redirect;
  logic [31:0] redirect_pc;

  // Stimulus source and reference model
  logic [31:0] lfsr = 32'h54af;
  logic [31:0] ref_regs [32];
  logic [31:0] ref_mscratch;
  uop_t        chain_ops [6];
  logic [31:0] chain_exp [6];
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_errors;
  logic        timed_out = 1'b0;

  exec_top #(.TIMER_W(32)) dut (
    .clk(clk), .reset(reset), .op_valid(op_valid), .op(op), .busy(busy),
    .wb(wb), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  always #5 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output logic [31:0] v);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report(input string name);
    tests++;
    $display("test %s: %0d errors", name, test_errors);
  endtask

  // Watcher that stops the run after a timeout
  initial begin
    wait (timed_out);
    $display("Simulation failed");
    $finish;
  end

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
    // Parked until the watcher ends the run
    forever @(posedge clk);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (busy) begin
      if (n == TIMEOUT) begin
        give_up("busy to drop");
      end
      n++;
      @(negedge clk);
    end
  endtask

  // Cycles counted from the edge that took the op
  task automatic wait_redirect(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!redirect) begin
      if (cycles == TIMEOUT) begin
        give_up("redirect");
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  function automatic uop_t make_uop(input op_e kind, input logic [4:0] rd,
                                    input logic [4:0] rs1, input logic [4:0] rs2,
                                    input logic [31:0] imm);
    uop_t u;
    u = '0;
    u.op = kind;
    u.rd = rd;
    u.rs1 = rs1;
    u.rs2 = rs2;
    u.imm = imm;
    return u;
  endfunction

  // Expected ALU result from the model registers
  function automatic logic [31:0] predict(input uop_t u);
    logic [31:0] a;
    logic [31:0] b;
    a = ref_regs[u.rs1];
    b = ref_regs[u.rs2];
    case (u.op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + u.imm;
      OP_LUI:  return u.imm;
      default: return 32'h0;
    endcase
  endfunction

  // Op held for one cycle, returns just after the edge that accepts it
  task automatic issue(input uop_t u);
    wait_idle();
    @(posedge clk);
    op_valid <= 1'b1;
    op <= u;
    @(posedge clk);
    op_valid <= 1'b0;
  endtask

  task automatic check_wb(input logic we, input logic [4:0] rd, input logic [31:0] data);
    check_val("wb.we", wb.we, we);
    if (we) begin
      check_val("wb.rd", wb.rd, rd);
      check_val("wb.data", wb.data, data);
    end
  endtask

  task automatic alu_step(input op_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [31:0] imm);
    uop_t        u;
    logic [31:0] exp;
    u = make_uop(kind, rd, rs1, rs2, imm);
    exp = predict(u);
    issue(u);
    @(negedge clk);
    // x0 target gives no write
    check_wb(rd != 5'd0, rd, exp);
    check_val("busy", busy, 1'b0);
    if (rd != 5'd0) begin
      ref_regs[rd] = exp;
    end
  endtask

  // Returns the old CSR value seen on wb
  task automatic csr_op(input op_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] addr, output logic [31:0] old);
    uop_t u;
    u = make_uop(kind, rd, rs1, 5'd0, 32'h0);
    u.csr = addr;
    issue(u);
    @(negedge clk);
    check_val("wb.we", wb.we, rd != 5'd0);
    old = wb.data;
    if (rd != 5'd0) begin
      ref_regs[rd] = old;
    end
  endtask

  // Value staged through x29
  task automatic csr_write(input logic [11:0] addr, input logic [31:0] value);
    logic [31:0] old;
    alu_step(OP_ADDI, 5'd29, 5'd0, 5'd0, value);
    csr_op(OP_CSRRW, 5'd0, 5'd29, addr, old);
  endtask

  task automatic test_alu();
    logic [31:0] v;
    test_errors = 0;
    for (int r = 1; r <= 5; r++) begin
      rand_word(v);
      alu_step(OP_ADDI, 5'(r), 5'd0, 5'd0, v);
    end
    rand_word(v);
    alu_step(OP_LUI, 5'd6, 5'd0, 5'd0, {v[31:12], 12'h0});
    alu_step(OP_ADD, 5'd7, 5'd1, 5'd2, 32'h0);
    alu_step(OP_SUB, 5'd8, 5'd3, 5'd4, 32'h0);
    alu_step(OP_AND, 5'd9, 5'd5, 5'd6, 32'h0);
    alu_step(OP_OR, 5'd10, 5'd1, 5'd6, 32'h0);
    alu_step(OP_XOR, 5'd11, 5'd2, 5'd3, 32'h0);
    // Write to x0, then read it back
    alu_step(OP_ADDI, 5'd0, 5'd1, 5'd0, 32'h1234);
    alu_step(OP_OR, 5'd12, 5'd0, 5'd0, 32'h0);
    alu_step(OP_ADD, 5'd12, 5'd0, 5'd4, 32'h0);
    report("alu_ops");
  endtask

  task automatic test_forwarding();
    logic [31:0] v;
    test_errors = 0;
    rand_word(v);
    chain_ops[0] = make_uop(OP_ADDI, 5'd13, 5'd0, 5'd0, v);
    chain_ops[1] = make_uop(OP_ADD, 5'd14, 5'd13, 5'd13, 32'h0);
    chain_ops[2] = make_uop(OP_SUB, 5'd15, 5'd14, 5'd13, 32'h0);
    chain_ops[3] = make_uop(OP_XOR, 5'd13, 5'd15, 5'd14, 32'h0);
    chain_ops[4] = make_uop(OP_OR, 5'd16, 5'd1, 5'd13, 32'h0);
    chain_ops[5] = make_uop(OP_ADDI, 5'd16, 5'd16, 5'd0, 32'h55);
    // Model in program order
    for (int i = 0; i < 6; i++) begin
      chain_exp[i] = predict(chain_ops[i]);
      ref_regs[chain_ops[i].rd] = chain_exp[i];
    end
    wait_idle();
    // Back to back, wb of op i-1 seen while op i is presented
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      op_valid <= 1'b1;
      op <= chain_ops[i];
      @(negedge clk);
      if (i > 0) begin
        check_wb(1'b1, chain_ops[i-1].rd, chain_exp[i-1]);
      end
    end
    @(posedge clk);
    op_valid <= 1'b0;
    @(negedge clk);
    check_wb(1'b1, chain_ops[5].rd, chain_exp[5]);
    report("forwarding");
  endtask

  task automatic test_csr();
    logic [31:0] v;
    logic [31:0] old;
    logic [31:0] t1;
    test_errors = 0;
    rand_word(v);
    alu_step(OP_ADDI, 5'd17, 5'd0, 5'd0, v);
    csr_op(OP_CSRRW, 5'd18, 5'd17, CSR_MSCRATCH, old);
    check_val("mscratch", old, ref_mscratch);
    ref_mscratch = ref_regs[17];
    rand_word(v);
    alu_step(OP_ADDI, 5'd17, 5'd0, 5'd0, v);
    csr_op(OP_CSRRW, 5'd19, 5'd17, CSR_MSCRATCH, old);
    check_val("mscratch", old, ref_mscratch);
    ref_mscratch = ref_regs[17];
    // rs1 = x0 is a plain read
    csr_op(OP_CSRRS, 5'd20, 5'd0, CSR_MSCRATCH, old);
    check_val("mscratch", old, ref_mscratch);
    csr_op(OP_CSRRS, 5'd20, 5'd0, CSR_MSCRATCH, old);
    check_val("mscratch", old, ref_mscratch);
    csr_op(OP_CSRRS, 5'd21, 5'd1, CSR_MSCRATCH, old);
    check_val("mscratch", old, ref_mscratch);
    ref_mscratch = ref_mscratch | ref_regs[1];
    csr_op(OP_CSRRS, 5'd21, 5'd0, CSR_MSCRATCH, old);
    check_val("mscratch", old, ref_mscratch);
    // Unknown address
    csr_op(OP_CSRRW, 5'd22, 5'd17, 12'h7FF, old);
    check_val("csr 0x7ff", old, 32'h0);
    csr_op(OP_CSRRS, 5'd22, 5'd0, 12'h7FF, old);
    check_val("csr 0x7ff", old, 32'h0);
    csr_op(OP_CSRRS, 5'd23, 5'd0, CSR_MTIME, t1);
    csr_op(OP_CSRRS, 5'd23, 5'd0, CSR_MTIME, old);
    check_val("mtime increases", old > t1, 1'b1);
    report("csr_ops");
  endtask

  task automatic test_ecall();
    uop_t        u;
    int          cycles;
    logic [31:0] old;
    test_errors = 0;
    csr_write(CSR_MTVEC, 32'h0000_1000);
    // MIE on so the entry has a bit to stack
    csr_write(CSR_MSTATUS, 32'h8);
    u = make_uop(OP_ECALL, 5'd0, 5'd0, 5'd0, 32'h0);
    u.pc = 32'h0000_0420;
    issue(u);
    wait_redirect(cycles);
    check_val("redirect delay", cycles, 0);
    check_val("redirect_pc", redirect_pc, 32'h0000_1000);
    check_val("busy", busy, 1'b1);
    check_val("wb.we", wb.we, 1'b0);
    @(negedge clk);
    check_val("busy", busy, 1'b0);
    check_val("redirect", redirect, 1'b0);
    csr_op(OP_CSRRS, 5'd24, 5'd0, CSR_MEPC, old);
    check_val("mepc", old, 32'h0000_0420);
    csr_op(OP_CSRRS, 5'd24, 5'd0, CSR_MCAUSE, old);
    check_val("mcause", old, 32'd11);
    // MPIE set, MIE cleared
    csr_op(OP_CSRRS, 5'd24, 5'd0, CSR_MSTATUS, old);
    check_val("mstatus", old, 32'h80);
    u = make_uop(OP_MRET, 5'd0, 5'd0, 5'd0, 32'h0);
    issue(u);
    wait_redirect(cycles);
    check_val("redirect delay", cycles, 0);
    check_val("redirect_pc", redirect_pc, 32'h0000_0420);
    check_val("busy", busy, 1'b1);
    @(negedge clk);
    check_val("busy", busy, 1'b0);
    csr_op(OP_CSRRS, 5'd24, 5'd0, CSR_MSTATUS, old);
    check_val("mstatus", old, 32'h88);
    report("ecall_mret");
  endtask

  task automatic test_timer();
    uop_t        u;
    logic [31:0] t;
    logic [31:0] old;
    logic [31:0] hit_pc;
    logic        hit;
    int          n;
    test_errors = 0;
    hit = 1'b0;
    hit_pc = 32'h0;
    n = 0;
    csr_write(CSR_MIE, 32'h80);
    csr_op(OP_CSRRS, 5'd25, 5'd0, CSR_MTIME, t);
    // Compare far enough out that setup finishes first
    csr_write(CSR_MTIMECMP, t + 32'd40);
    csr_write(CSR_MSTATUS, 32'h8);
    while (!hit) begin
      if (n == TIMEOUT) begin
        give_up("timer interrupt");
      end
      u = make_uop(OP_ADDI, 5'd26, 5'd26, 5'd0, 32'd1);
      u.pc = 32'h2000 + 32'(n * 4);
      issue(u);
      @(negedge clk);
      if (redirect) begin
        hit = 1'b1;
        hit_pc = u.pc;
        check_val("wb.we", wb.we, 1'b0);
        check_val("redirect_pc", redirect_pc, 32'h0000_1000);
      end else begin
        check_wb(1'b1, 5'd26, ref_regs[26] + 32'd1);
        ref_regs[26] = ref_regs[26] + 32'd1;
      end
      n++;
    end
    csr_op(OP_CSRRS, 5'd27, 5'd0, CSR_MCAUSE, old);
    check_val("mcause", old, 32'h8000_0007);
    csr_op(OP_CSRRS, 5'd27, 5'd0, CSR_MEPC, old);
    check_val("mepc", old, hit_pc);
    csr_op(OP_CSRRS, 5'd27, 5'd0, CSR_MSTATUS, old);
    check_val("mstatus.MIE", old[3], 1'b0);
    report("timer_irq");
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'h0;
    end
    ref_mscratch = 32'h0;
    reset = 1'b1;
    op_valid = 1'b0;
    op = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_alu();
    test_forwarding();
    test_csr();
    test_ecall();
    test_timer();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* compile.f */
common/rv_pkg.sv
regfile/reg_file.sv
regfile/csr_file.sv
logic/exec_alu.sv
logic/trap_ctrl.sv
logic/machine_timer.sv
logic/exec_top.sv
tb/exec_props.sv
tb/exec_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module exec_tb -Mdir obj_dir
out=$(./obj_dir/Vexec_tb 2>&1) || true
printf '%s\n' "$out"
echo "$out" | grep -q "Simulation passed"
